// ==== Makefile ====
# Verilator build and run for the trace path testbench

VERILATOR ?= verilator
TOP       ?= tb_trace_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== common/core_pkg.sv ====
package core_pkg;

    localparam int xlen        = 32;
    localparam int ilen        = 32;
    localparam int trace_depth = 4;
    localparam int order_w     = 64;

    localparam int reg_w  = 5;                    // register index
    localparam int mask_w = xlen / 8;             // one bit per byte lane
    localparam int ptr_w  = $clog2(trace_depth);

    // one retiring instruction as reported by the pipeline
    typedef struct packed {
        logic [ilen-1:0]  insn;
        logic             intr;
        logic             trap;
        logic [reg_w-1:0] rs1_addr;
        logic [reg_w-1:0] rs2_addr;
        logic [xlen-1:0]  rs1_rdata;
        logic [xlen-1:0]  rs2_rdata;
        logic [xlen-1:0]  pc_rdata;
        logic [xlen-1:0]  pc_wdata;               // sequential next pc
    } retire_ev_t;

    // register file write-back
    typedef struct packed {
        logic [reg_w-1:0] rd_addr;
        logic [xlen-1:0]  rd_wdata;
    } wb_ev_t;

    // taken branch, jump or redirect
    typedef struct packed {
        logic [xlen-1:0] target;
    } cf_ev_t;

    // data memory request, held by the core until retire
    typedef struct packed {
        logic [xlen-1:0]   addr;
        logic [mask_w-1:0] rmask;
        logic [mask_w-1:0] wmask;
        logic [xlen-1:0]   wdata;
    } mem_req_t;

    // merged retirement record
    typedef struct packed {
        logic [order_w-1:0] order;

        logic [ilen-1:0]    insn;
        logic               intr;
        logic               trap;

        logic [reg_w-1:0]   rs1_addr;
        logic [reg_w-1:0]   rs2_addr;
        logic [xlen-1:0]    rs1_rdata;
        logic [xlen-1:0]    rs2_rdata;

        logic [xlen-1:0]    pc_rdata;
        logic [xlen-1:0]    pc_wdata;

        logic [reg_w-1:0]   rd_addr;
        logic [xlen-1:0]    rd_wdata;

        logic [xlen-1:0]    mem_addr;
        logic [mask_w-1:0]  mem_rmask;
        logic [mask_w-1:0]  mem_wmask;
        logic [xlen-1:0]    mem_rdata;
        logic [xlen-1:0]    mem_wdata;
    } trace_rec_t;

endpackage

// ==== rvfi/rvfi_capture.sv ====
`timescale 1ns/1ns

module rvfi_capture (
    input  logic                      g_clk,
    input  logic                      g_resetn,

    input  logic                      retire_valid,
    input  core_pkg::retire_ev_t      retire,

    input  logic                      wb_valid,
    input  core_pkg::wb_ev_t          wb,

    input  logic                      cf_valid,
    input  core_pkg::cf_ev_t          cf,

    input  logic                      mem_req_valid,
    input  core_pkg::mem_req_t        mem_req,

    input  logic                      mem_rsp_valid,
    input  logic [core_pkg::xlen-1:0] mem_rsp_rdata,

    output logic                      rec_valid,
    output core_pkg::trace_rec_t      rec
);

    logic                          first_seen;   // pipeline-fill retire consumed
    logic [core_pkg::order_w-1:0]  order_q;

    logic                          wb_pend;
    core_pkg::wb_ev_t              wb_hold;
    logic                          cf_pend;
    core_pkg::cf_ev_t              cf_hold;
    logic                          mem_pend;
    logic [core_pkg::xlen-1:0]     rsp_q;        // last response word

    logic                          emit;
    logic                          wb_hit;
    core_pkg::wb_ev_t              wb_sel;
    logic                          mem_hit;
    core_pkg::trace_rec_t          rec_d;

    assign emit    = retire_valid && first_seen;
    assign wb_hit  = wb_valid || wb_pend;
    assign wb_sel  = wb_valid ? wb : wb_hold;    // same-cycle write-back wins
    assign mem_hit = mem_req_valid || mem_pend;

    always_comb begin
        rec_d           = '0;
        rec_d.order     = order_q;

        rec_d.insn      = retire.insn;
        rec_d.intr      = retire.intr;
        rec_d.trap      = retire.trap;

        rec_d.rs1_addr  = retire.rs1_addr;
        rec_d.rs2_addr  = retire.rs2_addr;
        rec_d.rs1_rdata = retire.rs1_rdata;
        rec_d.rs2_rdata = retire.rs2_rdata;

        rec_d.pc_rdata  = retire.pc_rdata;
        if (cf_valid) begin
            rec_d.pc_wdata = cf.target;
        end else if (cf_pend) begin
            rec_d.pc_wdata = cf_hold.target;
        end else begin
            rec_d.pc_wdata = retire.pc_wdata;
        end

        if (wb_hit) begin
            rec_d.rd_addr = wb_sel.rd_addr;
            if (wb_sel.rd_addr != '0) begin
                rec_d.rd_wdata = wb_sel.rd_wdata;
            end // x0 always reads back as zero
        end

        rec_d.mem_addr  = mem_req.addr;
        rec_d.mem_wdata = mem_req.wdata;
        if (mem_hit) begin
            rec_d.mem_rmask = mem_req.rmask;   // masks only when a request was issued
            rec_d.mem_wmask = mem_req.wmask;
        end

        rec_d.mem_rdata = mem_rsp_valid ? mem_rsp_rdata : rsp_q;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            first_seen <= 1'b0;
            order_q    <= '0;
            wb_pend    <= 1'b0;
            cf_pend    <= 1'b0;
            mem_pend   <= 1'b0;
            rsp_q      <= '0;
            rec_valid  <= 1'b0;
        end else begin
            rec_valid <= emit;

            if (retire_valid) begin
                first_seen <= 1'b1;
            end

            if (emit) begin
                order_q <= order_q + core_pkg::order_w'(1);
            end

            // pending events belong to the next retire only
            if (retire_valid) begin
                wb_pend <= 1'b0;
            end else if (wb_valid) begin
                wb_pend <= 1'b1;
            end

            if (retire_valid) begin
                cf_pend <= 1'b0;
            end else if (cf_valid) begin
                cf_pend <= 1'b1;
            end

            if (retire_valid) begin
                mem_pend <= 1'b0;
            end else if (mem_req_valid) begin
                mem_pend <= 1'b1;
            end

            if (mem_rsp_valid) begin
                rsp_q <= mem_rsp_rdata;          // carries over to later retires
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (wb_valid) begin
            wb_hold <= wb;
        end
        if (cf_valid) begin
            cf_hold <= cf;
        end
        if (emit) begin
            rec <= rec_d;
        end
    end

endmodule

// ==== rvfi/trace_fifo.sv ====
`timescale 1ns/1ns

module trace_fifo (
    input  logic                 g_clk,
    input  logic                 g_resetn,

    input  logic                 rec_valid,
    input  core_pkg::trace_rec_t rec,

    output logic                 trace_valid,
    output core_pkg::trace_rec_t trace,
    input  logic                 trace_ready,

    output logic                 overflow
);

    core_pkg::trace_rec_t           entries [core_pkg::trace_depth];

    logic [core_pkg::ptr_w-1:0]     wr_ptr;
    logic [core_pkg::ptr_w-1:0]     rd_ptr;
    logic [core_pkg::ptr_w:0]       count;

    logic                           full;
    logic                           push;
    logic                           pop;

    assign full        = count == (core_pkg::ptr_w + 1)'(core_pkg::trace_depth);
    assign trace_valid = count != '0;
    assign trace       = entries[rd_ptr];             // head entry drives the port

    assign pop  = trace_valid && trace_ready;
    assign push = rec_valid && (!full || pop);         // a pop frees the slot this cycle

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == core_pkg::ptr_w'(core_pkg::trace_depth - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end

            if (pop) begin
                rd_ptr <= (rd_ptr == core_pkg::ptr_w'(core_pkg::trace_depth - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            if (rec_valid && !push) begin
                overflow <= 1'b1;                      // sticky until reset
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (push) begin
            entries[wr_ptr] <= rec;
        end
    end

endmodule

// ==== sources.f ====
+incdir+test
common/core_pkg.sv
rvfi/rvfi_capture.sv
rvfi/trace_fifo.sv
src/trace_top.sv
test/tb_trace_top.sv

// ==== src/trace_top.sv ====
`timescale 1ns/1ns

module trace_top (
    input  logic                      g_clk,
    input  logic                      g_resetn,

    input  logic                      retire_valid,
    input  core_pkg::retire_ev_t      retire,
    input  logic                      wb_valid,
    input  core_pkg::wb_ev_t          wb,
    input  logic                      cf_valid,
    input  core_pkg::cf_ev_t          cf,
    input  logic                      mem_req_valid,
    input  core_pkg::mem_req_t        mem_req,
    input  logic                      mem_rsp_valid,
    input  logic [core_pkg::xlen-1:0] mem_rsp_rdata,

    output logic                      trace_valid,
    output core_pkg::trace_rec_t      trace,
    input  logic                      trace_ready,
    output logic                      overflow
);

    logic                 rec_valid;
    core_pkg::trace_rec_t rec;         // one-cycle record pulse into the buffer

    rvfi_capture rvfi_capture_i (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .retire_valid  (retire_valid),
        .retire        (retire),
        .wb_valid      (wb_valid),
        .wb            (wb),
        .cf_valid      (cf_valid),
        .cf            (cf),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata),
        .rec_valid     (rec_valid),
        .rec           (rec)
    );

    trace_fifo trace_fifo_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .rec_valid   (rec_valid),
        .rec         (rec),
        .trace_valid (trace_valid),
        .trace       (trace),
        .trace_ready (trace_ready),
        .overflow    (overflow)
    );

endmodule

// ==== test/tb_tasks.svh ====
// galois lfsr stepped once per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        val = {val[30:0], lsb};
    end
    return val;
endfunction

task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
        $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic compare_record(input core_pkg::trace_rec_t got, input core_pkg::trace_rec_t exp);
    check(64'(got.order), 64'(exp.order), "order");
    check(64'(got.insn), 64'(exp.insn), "insn");
    check(64'({got.intr, got.trap}), 64'({exp.intr, exp.trap}), "intr and trap");
    check(64'({got.rs1_addr, got.rs2_addr}), 64'({exp.rs1_addr, exp.rs2_addr}), "rs addr");
    check(64'(got.rs1_rdata), 64'(exp.rs1_rdata), "rs1_rdata");
    check(64'(got.rs2_rdata), 64'(exp.rs2_rdata), "rs2_rdata");
    check(64'(got.pc_rdata), 64'(exp.pc_rdata), "pc_rdata");
    check(64'(got.pc_wdata), 64'(exp.pc_wdata), "pc_wdata");
    check(64'(got.rd_addr), 64'(exp.rd_addr), "rd_addr");
    check(64'(got.rd_wdata), 64'(exp.rd_wdata), "rd_wdata");
    check(64'(got.mem_addr), 64'(exp.mem_addr), "mem_addr");
    check(64'({got.mem_rmask, got.mem_wmask}), 64'({exp.mem_rmask, exp.mem_wmask}), "masks");
    check(64'(got.mem_rdata), 64'(exp.mem_rdata), "mem_rdata");
    check(64'(got.mem_wdata), 64'(exp.mem_wdata), "mem_wdata");
endtask

task automatic model_clear();
    exp_q.delete();
    m_first    = 1'b0;
    m_order    = '0;
    m_wb_pend  = 1'b0;
    m_cf_pend  = 1'b0;
    m_rsp      = '0;
    m_overflow = 1'b0;
endtask

// reference model for one clock edge with the inputs driven for it
task automatic model_edge();
    core_pkg::trace_rec_t e;
    core_pkg::wb_ev_t     w;
    if (retire_valid && m_first) begin
        e           = '0;
        e.order     = m_order;
        e.insn      = retire.insn;
        e.intr      = retire.intr;
        e.trap      = retire.trap;
        e.rs1_addr  = retire.rs1_addr;
        e.rs2_addr  = retire.rs2_addr;
        e.rs1_rdata = retire.rs1_rdata;
        e.rs2_rdata = retire.rs2_rdata;
        e.pc_rdata  = retire.pc_rdata;
        e.pc_wdata  = cf_valid ? cf.target : (m_cf_pend ? m_cf.target : retire.pc_wdata);
        if (wb_valid || m_wb_pend) begin
            w          = wb_valid ? wb : m_wb;
            e.rd_addr  = w.rd_addr;
            e.rd_wdata = (w.rd_addr == 5'd0) ? 32'd0 : w.rd_wdata;
        end
        e.mem_addr  = mem_req.addr;
        e.mem_rmask = mem_req.rmask;
        e.mem_wmask = mem_req.wmask;
        e.mem_wdata = mem_req.wdata;
        e.mem_rdata = mem_rsp_valid ? mem_rsp_rdata : m_rsp;
        m_order     = m_order + 64'd1;
        if (exp_q.size() < core_pkg::trace_depth) begin
            exp_q.push_back(e);
        end else begin
            m_overflow = 1'b1;                // buffer full so the record is lost
        end
    end
    if (retire_valid) begin
        m_first   = 1'b1;
        m_wb_pend = 1'b0;
        m_cf_pend = 1'b0;
    end else begin
        if (wb_valid) begin
            m_wb_pend = 1'b1;
            m_wb      = wb;
        end
        if (cf_valid) begin
            m_cf_pend = 1'b1;
            m_cf      = cf;
        end
    end
    if (mem_rsp_valid) begin
        m_rsp = mem_rsp_rdata;
    end
endtask

task automatic cycle();
    model_edge();
    @(posedge g_clk);
    #1;
    retire_valid  = 1'b0;
    wb_valid      = 1'b0;
    cf_valid      = 1'b0;
    mem_req_valid = 1'b0;
    mem_rsp_valid = 1'b0;
endtask

task automatic init_inputs();
    g_resetn      = 1'b0;
    retire_valid  = 1'b0;
    retire        = '0;
    wb_valid      = 1'b0;
    wb            = '0;
    cf_valid      = 1'b0;
    cf            = '0;
    mem_req_valid = 1'b0;
    mem_req       = '0;
    mem_rsp_valid = 1'b0;
    mem_rsp_rdata = '0;
    trace_ready   = 1'b1;
endtask

task automatic apply_reset();
    g_resetn = 1'b0;
    model_clear();
    repeat (2) @(posedge g_clk);
    #1;
    g_resetn = 1'b1;
endtask

task automatic load_retire();
    retire.insn      = take_bits(32);
    retire.intr      = 1'(take_bits(1));
    retire.trap      = 1'(take_bits(1));
    retire.rs1_addr  = 5'(take_bits(5));
    retire.rs2_addr  = 5'(take_bits(5));
    retire.rs1_rdata = take_bits(32);
    retire.rs2_rdata = take_bits(32);
    retire.pc_rdata  = {30'(take_bits(30)), 2'b00};
    retire.pc_wdata  = retire.pc_rdata + 32'd4;
    retire_valid     = 1'b1;
endtask

task automatic load_wb(input logic [4:0] rd);
    wb.rd_addr  = rd;
    wb.rd_wdata = take_bits(32) | 32'h1;      // never zero, so x0 masking shows
    wb_valid    = 1'b1;
endtask

task automatic load_cf();
    cf.target = {30'(take_bits(30)), 2'b00};
    cf_valid  = 1'b1;
endtask

task automatic load_mem_req();
    mem_req.addr  = take_bits(32);
    mem_req.rmask = core_pkg::mask_w'(take_bits(core_pkg::mask_w));
    mem_req.wmask = core_pkg::mask_w'(take_bits(core_pkg::mask_w));
    mem_req.wdata = take_bits(32);
    mem_req_valid = 1'b1;
endtask

task automatic load_rsp();
    mem_rsp_rdata = take_bits(32);
    mem_rsp_valid = 1'b1;
endtask

task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || trace_valid) && n < drain_limit) begin
        cycle();
        n++;
    end
    if (exp_q.size() != 0 || trace_valid) begin
        $display("Trace buffer did not drain, %0d records still expected after %0d cycles",
                 exp_q.size(), drain_limit);
        errors++;
    end
endtask

task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
        $display("test %0d %s: ok", tests, name);
    end else begin
        $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    end
endtask

task automatic test_order();
    int err0;
    int seen0;
    err0  = errors;
    seen0 = rec_seen;
    repeat (5) begin
        load_retire();
        cycle();
        cycle();
    end
    wait_drain();
    check(64'(rec_seen - seen0), 64'd4, "records from 5 retires");
    report_test("order and first-retire drop", err0);
endtask

task automatic test_wb();
    int err0;
    err0 = errors;
    load_retire();
    load_wb(5'd1 + 5'(take_bits(4)));        // same cycle as the retire
    cycle();
    load_wb(5'd1 + 5'(take_bits(4)));        // two cycles ahead
    cycle();
    cycle();
    load_retire();
    cycle();
    load_retire();                           // no write-back at all
    cycle();
    load_retire();
    load_wb(5'd0);
    cycle();
    wait_drain();
    report_test("write-back merging", err0);
endtask

task automatic test_cf();
    int err0;
    err0 = errors;
    load_retire();
    load_cf();
    cycle();
    load_cf();
    cycle();
    load_retire();
    cycle();
    load_retire();                           // sequential next pc
    cycle();
    wait_drain();
    report_test("control flow", err0);
endtask

task automatic test_mem();
    int err0;
    err0 = errors;
    load_mem_req();                          // fields held until the retire
    cycle();
    cycle();
    load_rsp();
    cycle();
    load_retire();
    cycle();
    mem_req = '0;
    load_retire();                           // response word carries over
    cycle();
    load_mem_req();
    load_rsp();
    load_retire();
    cycle();
    mem_req = '0;
    wait_drain();
    report_test("memory", err0);
endtask

task automatic test_backpressure();
    int err0;
    int seen0;
    err0        = errors;
    trace_ready = 1'b0;
    repeat (6) begin
        load_retire();
        cycle();
    end
    repeat (3) cycle();
    check(64'(overflow), 64'(m_overflow), "overflow after 6 records");
    check(64'(trace_valid), 64'd1, "trace_valid while stalled");
    seen0       = rec_seen;
    trace_ready = 1'b1;
    wait_drain();
    check(64'(rec_seen - seen0), 64'(core_pkg::trace_depth), "records drained");
    report_test("back-pressure", err0);
endtask

task automatic test_reset();
    int err0;
    int seen0;
    err0        = errors;
    trace_ready = 1'b0;                      // a record is left in the buffer
    load_retire();
    cycle();
    repeat (2) cycle();
    check(64'(trace_valid), 64'd1, "trace_valid before reset");
    apply_reset();
    trace_ready = 1'b1;
    check(64'(overflow), 64'd0, "overflow after reset");
    check(64'(trace_valid), 64'd0, "trace_valid after reset");
    seen0 = rec_seen;
    repeat (3) begin
        load_retire();
        cycle();
    end
    wait_drain();
    check(64'(rec_seen - seen0), 64'd2, "records after reset");
    report_test("reset", err0);
endtask

// ==== test/tb_trace_top.sv ====
`timescale 1ns/1ns

module tb_trace_top;

    localparam int clk_period  = 4;
    localparam int test_cycles = 80;          // six tests plus the reset periods
    localparam int margin_ns   = 200;
    localparam int drain_limit = 20;

    logic                      g_clk = 1'b0;
    logic                      g_resetn;

    logic                      retire_valid;
    core_pkg::retire_ev_t      retire;
    logic                      wb_valid;
    core_pkg::wb_ev_t          wb;
    logic                      cf_valid;
    core_pkg::cf_ev_t          cf;
    logic                      mem_req_valid;
    core_pkg::mem_req_t        mem_req;
    logic                      mem_rsp_valid;
    logic [core_pkg::xlen-1:0] mem_rsp_rdata;

    logic                      trace_valid;
    core_pkg::trace_rec_t      trace;
    logic                      trace_ready;
    logic                      overflow;

    // reference model state
    core_pkg::trace_rec_t         exp_q [$];   // records expected out of the buffer
    logic                         m_first;
    logic [core_pkg::order_w-1:0] m_order;
    logic                         m_wb_pend;
    core_pkg::wb_ev_t             m_wb;
    logic                         m_cf_pend;
    core_pkg::cf_ev_t             m_cf;
    logic [core_pkg::xlen-1:0]    m_rsp;
    logic                         m_overflow;

    logic [31:0] lfsr = 32'ha9e0;
    int          errors   = 0;
    int          checks   = 0;
    int          tests    = 0;
    int          rec_seen = 0;

    trace_top trace_top_i (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .retire_valid  (retire_valid),
        .retire        (retire),
        .wb_valid      (wb_valid),
        .wb            (wb),
        .cf_valid      (cf_valid),
        .cf            (cf),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata),
        .trace_valid   (trace_valid),
        .trace         (trace),
        .trace_ready   (trace_ready),
        .overflow      (overflow)
    );

    always #(clk_period / 2) g_clk = ~g_clk;

    `include "tb_tasks.svh"

    // the transfer happens on the rising edge after this sample
    always @(negedge g_clk) begin
        if (g_resetn && trace_valid && trace_ready) begin
            rec_seen++;
            if (exp_q.size() == 0) begin
                $display("Trace record with order %0d came out but none was expected",
                         trace.order);
                errors++;
            end else begin
                compare_record(trace, exp_q.pop_front());
            end
        end
    end

    initial begin
        #(test_cycles * clk_period + margin_ns);
        $display("Timeout: the tests did not finish within %0d ns",
                 test_cycles * clk_period + margin_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        init_inputs();
        apply_reset();
        test_order();
        test_wb();
        test_cf();
        test_mem();
        test_backpressure();
        test_reset();
        $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
